// ==== bench/i2c_init_tb.sv ====
/*
 * I2C init engine testbench
 * slave model with clock stretching decodes the bus into transactions,
 * scored against the command table rules over several start runs, one with a NACK
 */
`timescale 1ns/1ps
`include "i2c_init_defines.svh"

module i2c_init_tb;

    localparam int NUM_RUNS = 3;
    localparam int BIT_CYCLES = 4 * `I2C_QUARTER + 13;  // one bit, worst stretch
    localparam int RUN_LIMIT = 24 * 9 * BIT_CYCLES;
    localparam int QUIET = 100;                         // idle window after a run

    logic clk;
    logic rst;
    logic start;
    logic scl_o;
    logic sda_o;
    logic init_busy;
    logic bus_busy;
    logic nack;
    logic slv_scl = 1'b1;   // slave side of the open-drain pins
    logic slv_sda = 1'b1;
    logic scl_bus;
    logic sda_bus;

    int  err_count;
    int  check_count;
    int  timeout_count;
    bit  timed_out;
    bit  nack_en;           // slave refuses nack_addr this run
    int  nack_addr;
    int  nack_count;
    int  stretch_tab [256];
    int  exp_addr [$];
    int  exp_len [$];
    int  exp_bytes [$];
    int  rx_addr [$];
    int  rx_len [$];
    int  rx_bytes [$];

    // slave decode state
    int  cyc;
    int  hi_start;          // cycle of the last SCL rise
    int  hold;              // stretch cycles left
    int  st_idx;
    bit  prev_scl;
    bit  prev_sda;
    bit  in_tx;
    bit  in_ack;
    bit  first_byte;
    int  bit_cnt;
    int  shift;
    int  cur_addr;
    int  cur_len;

    assign scl_bus = scl_o & slv_scl;  // wired-AND bus
    assign sda_bus = sda_o & slv_sda;

    tb_clock_gen u_clk (
        .clk (clk)
    );

    i2c_init_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .scl_i     (scl_bus),
        .sda_i     (sda_bus),
        .scl_o     (scl_o),
        .sda_o     (sda_o),
        .init_busy (init_busy),
        .bus_busy  (bus_busy),
        .nack      (nack)
    );

    task automatic check_value(input string name, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            err_count++;
            $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // bus released and engine quiet
    task automatic expect_idle();
        check_value("scl", int'(scl_bus), 1);
        check_value("sda", int'(sda_bus), 1);
        check_value("init_busy", int'(init_busy), 0);
        check_value("bus_busy", int'(bus_busy), 0);
        check_value("nack", int'(nack), 0);
    endtask

    // which 0 is init_busy, 1 is bus_busy
    task automatic wait_level(input int which, input bit level, input int limit,
                              input string what);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!timed_out && !seen) begin
            @(negedge clk);
            seen = (((which == 0) ? init_busy : bus_busy) == level);
            n++;
            if (!seen && n >= limit) begin
                $display("timeout: %s did not happen within %0d cycles", what, limit);
                timeout_count++;
                timed_out = 1'b1;
            end
        end
    endtask

    // expected writes straight from the table rules
    task automatic build_expected(input bit nack_run, input int refused);
        int blk [3];
        int devs [3];
        exp_addr.delete();
        exp_len.delete();
        exp_bytes.delete();
        blk = '{'h10, 'hA5, 'h3C};   // data block
        devs = '{'h51, 'h52, 'h53};  // address block order
        exp_addr.push_back('h50);
        if (nack_run && refused == 'h50) begin
            exp_len.push_back(0);    // refused address, no bytes follow
        end else begin
            exp_len.push_back(2);
            exp_bytes.push_back('h04);
            exp_bytes.push_back('h81);
        end
        foreach (devs[i]) begin
            exp_addr.push_back(devs[i]);
            if (nack_run && refused == devs[i]) begin
                exp_len.push_back(0);
            end else begin
                exp_len.push_back($size(blk));
                foreach (blk[j]) exp_bytes.push_back(blk[j]);
            end
        end
        exp_addr.push_back('h20);    // single-device again after exit
        if (nack_run && refused == 'h20) begin
            exp_len.push_back(0);
        end else begin
            exp_len.push_back(1);
            exp_bytes.push_back('h5A);
        end
    endtask

    task automatic score_run(input bit nack_run);
        check_value("tx_count", rx_addr.size(), exp_addr.size());
        check_value("byte_count", rx_bytes.size(), exp_bytes.size());
        for (int i = 0; i < exp_addr.size() && i < rx_addr.size(); i++) begin
            check_value("tx_addr", rx_addr[i], exp_addr[i]);
            check_value("tx_len", rx_len[i], exp_len[i]);
        end
        for (int i = 0; i < exp_bytes.size() && i < rx_bytes.size(); i++) begin
            check_value("tx_byte", rx_bytes[i], exp_bytes[i]);
        end
        check_value("nack_pulses", nack_count, nack_run ? 1 : 0);
    endtask

    task automatic run_table(input bit nack_run);
        int delay;
        int hold_hi;
        int n;
        bit done;
        int pool [5];
        pool = '{'h50, 'h51, 'h52, 'h53, 'h20};   // every device the table opens
        nack_addr = pool[$urandom % 5];
        nack_en = nack_run;
        nack_count = 0;
        rx_addr.delete();
        rx_len.delete();
        rx_bytes.delete();
        build_expected(nack_run, nack_addr);
        delay = 1 + int'($urandom % 32);
        repeat (delay) begin
            @(negedge clk);
            expect_idle();   // nothing on the bus before start
        end
        start <= 1'b1;
        wait_level(0, 1'b1, 8, "init_busy rise after start");
        hold_hi = int'($urandom % 6);
        repeat (hold_hi) @(negedge clk);   // held level
        start <= 1'b0;
        n = 0;
        done = 1'b0;
        while (!timed_out && !done) begin
            @(negedge clk);
            if (!init_busy) begin
                done = 1'b1;
            end else begin
                start <= ($urandom % 64 == 0);  // stray start while busy
                n++;
                if (n >= RUN_LIMIT) begin
                    $display("timeout: init_busy stayed high for %0d cycles", RUN_LIMIT);
                    timeout_count++;
                    timed_out = 1'b1;
                end
            end
        end
        start <= 1'b0;
        wait_level(1, 1'b0, 16 * `I2C_QUARTER + 26, "bus_busy fall after init_busy");
        if (!timed_out) begin
            repeat (QUIET) begin
                @(negedge clk);
                expect_idle();   // no second run
            end
            score_run(nack_run);
        end
    endtask

    // slave model, samples and drives on the falling clk edge
    always @(negedge clk) begin
        cyc++;
        if (rst) begin
            slv_scl <= 1'b1;
            slv_sda <= 1'b1;
            prev_scl = 1'b1;
            prev_sda = 1'b1;
            in_tx = 1'b0;
            in_ack = 1'b0;
            hold = 0;
            hi_start = cyc;
        end else begin
            if (nack) nack_count++;
            if (hold > 0) begin
                hold--;
                if (hold == 0) slv_scl <= 1'b1;  // end of stretch
            end
            if (scl_bus && !prev_scl) hi_start = cyc;
            if (!scl_bus && prev_scl) begin
                if (cyc - hi_start < `I2C_QUARTER) begin
                    check_value("scl_high_cycles", cyc - hi_start, `I2C_QUARTER);
                end
                hold = stretch_tab[st_idx];    // hold SCL low after each fall
                st_idx = (st_idx + 1) % 256;
                if (hold > 0) slv_scl <= 1'b0;
            end
            if (scl_bus && prev_scl && prev_sda && !sda_bus) begin
                in_tx = 1'b1;                  // START
                in_ack = 1'b0;
                first_byte = 1'b1;
                bit_cnt = 0;
                cur_len = 0;
            end else if (scl_bus && prev_scl && !prev_sda && sda_bus) begin
                if (in_tx) begin               // STOP closes the transaction
                    rx_addr.push_back(cur_addr);
                    rx_len.push_back(cur_len);
                end
                in_tx = 1'b0;
            end else if (in_tx && scl_bus && !prev_scl && !in_ack) begin
                shift = ((shift << 1) | int'(sda_bus)) & 'hFF;  // MSB first
                bit_cnt++;
            end else if (in_tx && !scl_bus && prev_scl) begin
                if (in_ack) begin
                    slv_sda <= 1'b1;           // ninth clock done
                    in_ack = 1'b0;
                    bit_cnt = 0;
                end else if (bit_cnt == 8) begin
                    in_ack = 1'b1;
                    if (first_byte) begin
                        cur_addr = shift >> 1;
                        check_value("rw_bit", shift & 1, 0);  // writes only
                        first_byte = 1'b0;
                        if (!(nack_en && cur_addr == nack_addr)) slv_sda <= 1'b0;
                    end else begin
                        rx_bytes.push_back(shift);
                        cur_len++;
                        slv_sda <= 1'b0;
                    end
                end
            end
            check_value("bus_busy", int'(bus_busy), int'(in_tx));  // START to STOP
            prev_scl = scl_bus;
            prev_sda = sda_bus;
        end
    end

    initial begin
        int nack_run_idx;
        rst = 1'b1;
        start = 1'b0;
        void'($urandom(32'h618aba98));
        foreach (stretch_tab[i]) stretch_tab[i] = int'($urandom % 13);  // 0 to 12
        nack_run_idx = int'($urandom % NUM_RUNS);
        repeat (16) @(negedge clk);
        rst <= 1'b0;
        for (int r = 0; r < NUM_RUNS; r++) begin
            if (!timed_out) begin
                $display("run %0d%s", r, (r == nack_run_idx) ? " with NACK" : "");
                run_table(r == nack_run_idx);
            end
        end
        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count,
                 timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
/*
 * testbench clock source
 * free-running clk, 4 ns period
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 2 ns half period
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/i2c_init_pkg.sv
hdl/init_table_rom.sv
hdl/init_sequencer.sv
hdl/i2c_write_master.sv
hdl/i2c_init_top.sv
bench/tb_clock_gen.sv
bench/i2c_init_tb.sv

// ==== hdl/i2c_init_defines.svh ====
/*
 * I2C init engine build constants
 * table size and bus timing, shared by the ROM, sequencer and bit engine
 */
`ifndef I2C_INIT_DEFINES_SVH
`define I2C_INIT_DEFINES_SVH

// command table
`define INIT_TABLE_LEN 26   // entries, tail is padded with stop
`define INIT_ADDR_W 5       // enough for INIT_TABLE_LEN

// bus timing, one SCL period is four quarters
`define I2C_QUARTER 5       // clk cycles per quarter

`endif

// ==== hdl/i2c_init_pkg.sv ====
/*
 * I2C init engine types
 * table word, command decode, bus command and FSM state encodings
 */
`include "i2c_init_defines.svh"

package i2c_init_pkg;

    typedef logic [`INIT_ADDR_W-1:0] init_addr_t;  // table index

    // 9-bit table word, a data entry uses {addr, payload} as the byte
    typedef struct packed {
        logic       data;     // 1 = write data byte
        logic       addr;     // 1 = start write to payload address
        logic [6:0] payload;
    } init_entry_t;

    typedef enum logic [2:0] {
        OP_STOP,
        OP_EXIT_MULTI,
        OP_WRITE_CUR,      // start write to current device
        OP_ADDR_BLOCK,
        OP_DATA_BLOCK,
        OP_WRITE_ADDR,
        OP_WRITE_DATA,
        OP_INVALID
    } init_op_e;

    // command word to the bit engine
    typedef struct packed {
        logic [6:0] addr;
        logic       start;
        logic       write;
        logic       stop;
    } i2c_cmd_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_RUN,              // single-device mode
        SEQ_FIND_ADDR_BLOCK,  // skipping over the data block
        SEQ_NEXT_ADDR,        // fetch next device address
        SEQ_DATA_BLOCK        // replay data block for cur address
    } seq_state_e;

    typedef enum logic [2:0] {
        MST_IDLE,
        MST_START,
        MST_BIT,
        MST_ACK,
        MST_STOP
    } mst_state_e;

endpackage

// ==== hdl/i2c_init_top.sv ====
/*
 * power-on I2C configuration engine
 * command ROM, table sequencer and write-only bit engine on one open-drain bus
 */
`timescale 1ns/1ps

module i2c_init_top
    import i2c_init_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_o,     // low pulls SCL down
    output logic sda_o,     // low pulls SDA down
    output logic init_busy,
    output logic bus_busy,
    output logic nack
);

    init_addr_t  rom_addr;
    init_entry_t rom_entry;
    i2c_cmd_t    cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    logic [7:0]  data;
    logic        data_valid;
    logic        data_ready;

    init_table_rom u_rom (
        .clk       (clk),
        .rom_addr  (rom_addr),
        .rom_entry (rom_entry)
    );

    init_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .rom_addr   (rom_addr),
        .rom_entry  (rom_entry),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .data       (data),
        .data_valid (data_valid),
        .data_ready (data_ready),
        .init_busy  (init_busy)
    );

    i2c_write_master u_mst (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .data       (data),
        .data_valid (data_valid),
        .data_ready (data_ready),
        .scl_i      (scl_i),
        .sda_i      (sda_i),
        .scl_o      (scl_o),
        .sda_o      (sda_o),
        .bus_busy   (bus_busy),
        .nack       (nack)
    );

endmodule

// ==== hdl/i2c_write_master.sv ====
/*
 * write-only I2C bit engine
 * START, address and data bytes MSB first, ack sampling and STOP on open-drain
 * pins, with clock stretching and NACK abort
 */
`timescale 1ns/1ps
`include "i2c_init_defines.svh"

module i2c_write_master
    import i2c_init_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  i2c_cmd_t   cmd,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  logic [7:0] data,
    input  logic       data_valid,
    output logic       data_ready,
    input  logic       scl_i,
    input  logic       sda_i,
    output logic       scl_o,
    output logic       sda_o,
    output logic       bus_busy,
    output logic       nack
);

    localparam int TW = $clog2(`I2C_QUARTER + 1);
    localparam logic [TW-1:0] QLOAD = TW'(`I2C_QUARTER - 1);

    mst_state_e    state;
    logic [1:0]    ph;          // quarter within the current step
    logic [TW-1:0] tmr;
    logic [2:0]    bitn;
    logic [7:0]    sh;          // outgoing byte
    logic [7:0]    data_q;
    logic [6:0]    addr_q;
    logic [6:0]    last_addr;   // device of the open transfer
    logic          active;      // between START and STOP
    logic          drop;        // discarding after a NACK
    logic          is_addr;
    logic          go_start;    // START after the STOP in progress
    logic          go_wr;
    logic          go_stop;
    logic          ack_bad;
    logic          stall;
    logic          tick;
    logic          accept;
    logic          need_start;

    assign stall = scl_o && !scl_i;  // slave holding SCL low
    assign tick = (state != MST_IDLE) && (tmr == '0) && !stall;
    // command and its byte are taken together
    assign cmd_ready = (state == MST_IDLE) && (!cmd.write || data_valid);
    assign data_ready = (state == MST_IDLE) && cmd_valid && cmd.write;
    assign accept = cmd_valid && cmd_ready;
    assign need_start = (cmd.start || cmd.write) && (!active || cmd.addr != last_addr);
    assign bus_busy = active;

    always_ff @(posedge clk) begin
        nack <= 1'b0;
        if (rst) begin
            state <= MST_IDLE;
            ph <= 2'd0;
            tmr <= QLOAD;
            bitn <= '0;
            scl_o <= 1'b1;
            sda_o <= 1'b1;
            active <= 1'b0;
            drop <= 1'b0;
            go_start <= 1'b0;
            go_wr <= 1'b0;
            go_stop <= 1'b0;
        end else begin
            if (state != MST_IDLE && !stall) begin
                tmr <= (tmr == '0) ? QLOAD : tmr - 1'b1;
            end
            if (tick) begin
                ph <= ph + 1'b1;
            end
            unique case (state)
                MST_IDLE: begin
                    if (accept) begin
                        data_q <= data;
                        addr_q <= cmd.addr;
                        go_wr <= cmd.write;
                        go_stop <= cmd.stop;
                        go_start <= need_start && active;
                        if (!drop || cmd.start) begin   // new start ends the discard
                            drop <= 1'b0;
                            if (need_start) begin
                                state <= active ? MST_STOP : MST_START;
                            end else if (cmd.write) begin
                                sh <= data;     // same device, continue
                                is_addr <= 1'b0;
                                state <= MST_BIT;
                            end else if (cmd.stop && active) begin
                                state <= MST_STOP;
                            end
                        end
                    end
                end
                MST_START: begin
                    if (tick) begin
                        if (ph == 2'd0) begin
                            sda_o <= 1'b0;  // SDA falls with SCL high
                            active <= 1'b1;
                        end else begin
                            scl_o <= 1'b0;
                            ph <= 2'd0;
                            sh <= {addr_q, 1'b0};   // write direction
                            last_addr <= addr_q;
                            is_addr <= 1'b1;
                            state <= MST_BIT;
                        end
                    end
                end
                MST_BIT: begin
                    if (tick) begin
                        case (ph)
                            2'd0: sda_o <= sh[7];   // change only while SCL low
                            2'd1: scl_o <= 1'b1;
                            2'd3: begin
                                scl_o <= 1'b0;
                                sh <= {sh[6:0], 1'b0};
                                bitn <= bitn + 1'b1;  // wraps to 0 after bit 7
                                if (bitn == 3'd7) state <= MST_ACK;
                            end
                            default: ;
                        endcase
                    end
                end
                MST_ACK: begin
                    if (tick) begin
                        case (ph)
                            2'd0: sda_o <= 1'b1;    // hand SDA to the slave
                            2'd1: scl_o <= 1'b1;
                            2'd2: ack_bad <= sda_i;
                            default: begin
                                scl_o <= 1'b0;
                                if (ack_bad) begin
                                    nack <= 1'b1;
                                    drop <= 1'b1;
                                    go_wr <= 1'b0;  // no data after a refused address
                                    go_start <= 1'b0;   // and no second START
                                    state <= MST_STOP;
                                end else if (is_addr && go_wr) begin
                                    sh <= data_q;
                                    is_addr <= 1'b0;
                                    state <= MST_BIT;
                                end else begin
                                    state <= go_stop ? MST_STOP : MST_IDLE;
                                end
                            end
                        endcase
                    end
                end
                MST_STOP: begin
                    if (tick) begin
                        case (ph)
                            2'd0: sda_o <= 1'b0;
                            2'd1: scl_o <= 1'b1;
                            2'd2: begin
                                sda_o <= 1'b1;  // SDA rises with SCL high
                                active <= 1'b0;
                            end
                            default: state <= go_start ? MST_START : MST_IDLE;
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/init_sequencer.sv ====
/*
 * command table interpreter
 * walks the ROM after a start edge and emits bus commands plus data bytes,
 * replaying a data block once per device in multi-device mode
 */
`timescale 1ns/1ps
`include "i2c_init_defines.svh"

module init_sequencer
    import i2c_init_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    output init_addr_t  rom_addr,
    input  init_entry_t rom_entry,
    output i2c_cmd_t    cmd,
    output logic        cmd_valid,
    input  logic        cmd_ready,
    output logic [7:0]  data,
    output logic        data_valid,
    input  logic        data_ready,
    output logic        init_busy
);

    seq_state_e state;
    seq_state_e state_n;
    init_addr_t addr;       // entry now on rom_entry
    init_addr_t addr_n;
    init_addr_t addr_ptr;   // next entry of the address block
    init_addr_t addr_ptr_n;
    init_addr_t data_ptr;   // first entry of the data block
    init_addr_t data_ptr_n;
    logic [6:0] cur_addr;
    logic [6:0] cur_addr_n;
    i2c_cmd_t   cmd_n;
    logic       cmd_valid_n;
    logic [7:0] data_n;
    logic       data_valid_n;
    logic       start_q;
    logic       emit;       // states that put writes on the bus
    init_op_e   op;

    function automatic init_op_e decode(init_entry_t e);
        if (e.data) return OP_WRITE_DATA;
        if (e.addr) return OP_WRITE_ADDR;
        case (e.payload)
            7'h00:   return OP_STOP;
            7'h01:   return OP_EXIT_MULTI;
            7'h03:   return OP_WRITE_CUR;
            7'h08:   return OP_ADDR_BLOCK;
            7'h09:   return OP_DATA_BLOCK;
            default: return OP_INVALID;
        endcase
    endfunction

    assign op = (addr < `INIT_TABLE_LEN) ? decode(rom_entry) : OP_STOP;  // ran off the end
    assign emit = (state == SEQ_RUN) || (state == SEQ_DATA_BLOCK);
    assign rom_addr = addr_n;   // ROM registers it
    assign init_busy = (state != SEQ_IDLE) || cmd_valid || data_valid;

    always_comb begin
        state_n = state;
        addr_n = addr;
        addr_ptr_n = addr_ptr;
        data_ptr_n = data_ptr;
        cur_addr_n = cur_addr;
        cmd_n = cmd;
        cmd_valid_n = cmd_valid && !cmd_ready;
        data_n = data;
        data_valid_n = data_valid && !data_ready;
        if (cmd_valid && cmd_ready) begin
            // flags are one-shot, address stays
            cmd_n.start = 1'b0;
            cmd_n.write = 1'b0;
            cmd_n.stop = 1'b0;
        end
        if (!cmd_valid && !data_valid) begin  // hold while a word is pending
            if (state == SEQ_IDLE) begin
                if (start && !start_q) begin
                    addr_n = '0;
                    state_n = SEQ_RUN;
                end
            end else begin
                addr_n = addr + 1'b1;   // usual step
                case (op)
                    OP_STOP: begin
                        cmd_n.start = 1'b0;
                        cmd_n.write = 1'b0;
                        cmd_n.stop = 1'b1;
                        cmd_valid_n = 1'b1;
                        addr_n = addr;
                        state_n = SEQ_IDLE;
                    end
                    OP_EXIT_MULTI: state_n = SEQ_RUN;
                    OP_DATA_BLOCK: begin
                        data_ptr_n = addr + 1'b1;
                        state_n = SEQ_FIND_ADDR_BLOCK;
                    end
                    OP_ADDR_BLOCK: begin
                        if (state == SEQ_FIND_ADDR_BLOCK) begin
                            addr_ptr_n = addr + 1'b1;
                            state_n = SEQ_NEXT_ADDR;
                        end else if (state == SEQ_DATA_BLOCK) begin
                            addr_n = addr_ptr;  // end of data block, next device
                            state_n = SEQ_NEXT_ADDR;
                        end
                    end
                    OP_WRITE_ADDR: begin
                        if (state == SEQ_NEXT_ADDR) begin
                            cur_addr_n = rom_entry.payload;
                            addr_ptr_n = addr + 1'b1;
                            addr_n = data_ptr;  // jump back into data block
                            state_n = SEQ_DATA_BLOCK;
                        end else if (emit) begin
                            cmd_n.addr = rom_entry.payload;
                            cmd_n.start = 1'b1;  // rides on the next write
                        end
                    end
                    OP_WRITE_CUR: begin
                        if (state == SEQ_DATA_BLOCK) begin
                            cmd_n.addr = cur_addr;
                            cmd_n.start = 1'b1;
                        end
                    end
                    OP_WRITE_DATA: begin
                        if (emit) begin
                            cmd_n.write = 1'b1;
                            cmd_n.stop = 1'b0;
                            cmd_valid_n = 1'b1;
                            data_n = {rom_entry.addr, rom_entry.payload};
                            data_valid_n = 1'b1;
                        end
                    end
                    default: ;  // invalid entry, step over
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            addr <= '0;
            addr_ptr <= '0;
            data_ptr <= '0;
            cmd <= '0;
            cmd_valid <= 1'b0;
            data_valid <= 1'b0;
            start_q <= 1'b0;
        end else begin
            state <= state_n;
            addr <= addr_n;
            addr_ptr <= addr_ptr_n;
            data_ptr <= data_ptr_n;
            cmd <= cmd_n;
            cmd_valid <= cmd_valid_n;
            data_valid <= data_valid_n;
            start_q <= start;   // edge detect, a held level does not rerun
        end
        cur_addr <= cur_addr_n;
        data <= data_n;
    end

endmodule

// ==== hdl/init_table_rom.sv ====
/*
 * configuration command table
 * synchronous ROM, entry appears one cycle after its address
 */
`timescale 1ns/1ps
`include "i2c_init_defines.svh"

module init_table_rom
    import i2c_init_pkg::*;
(
    input  logic        clk,
    input  init_addr_t  rom_addr,
    output init_entry_t rom_entry
);

    init_entry_t mem [`INIT_TABLE_LEN];

    initial begin
        for (int i = 0; i < `INIT_TABLE_LEN; i++) begin
            mem[i] = '0;  // unused tail reads as stop
        end
        // single device 0x50, two bytes
        mem[0]  = {2'b01, 7'h50};   // start write to 0x50
        mem[1]  = {1'b1, 8'h04};    // register 0x04
        mem[2]  = {1'b1, 8'h81};    // value
        mem[3]  = 9'h002;           // unused opcode, skipped
        // same register block for three devices
        mem[4]  = 9'h009;           // start data block
        mem[5]  = 9'h003;           // write to current device
        mem[6]  = {1'b1, 8'h10};    // register 0x10
        mem[7]  = {1'b1, 8'hA5};
        mem[8]  = {1'b1, 8'h3C};
        mem[9]  = 9'h008;           // start address block
        mem[10] = {2'b01, 7'h51};
        mem[11] = {2'b01, 7'h52};
        mem[12] = {2'b01, 7'h53};
        mem[13] = 9'h001;           // back to single-device mode
        // one byte to 0x20
        mem[14] = {2'b01, 7'h20};
        mem[15] = {1'b1, 8'h5A};
        mem[16] = 9'h000;           // stop, end of run
    end

    // out-of-range index reads as stop
    always_ff @(posedge clk) begin
        rom_entry <= (rom_addr < `INIT_TABLE_LEN) ? mem[rom_addr] : '0;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the I2C init engine testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module i2c_init_tb -o i2c_init_sim || exit 1
out=$(./obj_dir/i2c_init_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF "All tests passed!" && echo "PASS" || { echo "FAIL"; exit 1; }
